// File: hw/gfx_pkg.sv
`default_nettype none
// ##########################################################
// drawing types, 16-colour palette and the castle shape table
// shared by the sequencer, the rasterizer and the testbench
// ##########################################################

package gfx_pkg;
    typedef logic [9:0] coord_t;  // framebuffer or display coordinate
    typedef logic [3:0] cidx_t;   // colour index

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    typedef struct packed {
        coord_t x0;
        coord_t y0;
        coord_t x1;  // corners are inclusive
        coord_t y1;
        cidx_t  cidx;
    } shape_t;

    localparam int SHAPE_CNT = 19;

    localparam rgb_t PALETTE [16] = '{
        12'h000, 12'h235, 12'h725, 12'h085,  // black, dark blue, dark purple, dark green
        12'hA53, 12'h655, 12'hCCC, 12'hFFE,  // brown, dark grey, light grey, white
        12'hF04, 12'hFA0, 12'hFE2, 12'h0E3,  // warm colours and green
        12'h2AF, 12'h87A, 12'hF7A, 12'hFCA
    };

    // roofs are drawn as boxes since there is no triangle fill
    localparam shape_t SHAPES [SHAPE_CNT] = '{
        '{10'd60,  10'd70, 10'd190, 10'd120, 4'h5},  // main building
        '{10'd110, 10'd90, 10'd140, 10'd120, 4'h4},  // drawbridge
        '{10'd110, 10'd90, 10'd115, 10'd95,  4'h5},  // arch left
        '{10'd135, 10'd90, 10'd140, 10'd95,  4'h5},  // arch right
        '{10'd40,  10'd45, 10'd60,  10'd120, 4'h5},  // left tower
        '{10'd110, 10'd40, 10'd140, 10'd70,  4'h5},  // middle tower
        '{10'd190, 10'd45, 10'd210, 10'd120, 4'h5},  // right tower
        '{10'd38,  10'd32, 10'd62,  10'd44,  4'h2},  // left roof
        '{10'd108, 10'd24, 10'd142, 10'd39,  4'h2},  // middle roof
        '{10'd188, 10'd32, 10'd212, 10'd44,  4'h2},  // right roof
        '{10'd46,  10'd50, 10'd54,  10'd65,  4'h1},  // left window
        '{10'd120, 10'd45, 10'd130, 10'd65,  4'h1},  // middle window
        '{10'd196, 10'd50, 10'd204, 10'd65,  4'h1},  // right window
        '{10'd63,  10'd62, 10'd72,  10'd70,  4'h5},  // battlements
        '{10'd80,  10'd62, 10'd89,  10'd70,  4'h5},
        '{10'd97,  10'd62, 10'd106, 10'd70,  4'h5},
        '{10'd144, 10'd62, 10'd153, 10'd70,  4'h5},
        '{10'd161, 10'd62, 10'd170, 10'd70,  4'h5},
        '{10'd178, 10'd62, 10'd187, 10'd70,  4'h5}
    };
endpackage

`default_nettype wire

// File: hw/video_pkg.sv
`default_nettype none
// ##########################################################
// 640x480 60 Hz timing, letterbox rows and background bands
// ##########################################################

package video_pkg;
    import gfx_pkg::*;

    localparam coord_t H_ACTIVE = 10'd640;
    localparam coord_t H_FRONT  = 10'd16;
    localparam coord_t H_SYNC   = 10'd96;
    localparam coord_t H_BACK   = 10'd48;
    localparam coord_t H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;  // 800

    localparam coord_t V_ACTIVE = 10'd480;
    localparam coord_t V_FRONT  = 10'd10;
    localparam coord_t V_SYNC   = 10'd2;
    localparam coord_t V_BACK   = 10'd33;
    localparam coord_t V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;  // 525

    localparam coord_t LBOX_TOP    = 10'd60;   // 16:9 letterbox
    localparam coord_t LBOX_BOTTOM = 10'd420;

    typedef struct packed {
        coord_t row;   // first display row of the band
        rgb_t   colr;
    } bg_band_t;

    localparam int BG_CNT = 10;
    localparam bg_band_t BG_BANDS [BG_CNT] = '{
        '{10'd0,   12'h000}, '{10'd60,  12'h239}, '{10'd130, 12'h24A}, '{10'd175, 12'h25B},
        '{10'd210, 12'h26C}, '{10'd240, 12'h27D}, '{10'd265, 12'h29E}, '{10'd285, 12'h2BF},
        '{10'd302, 12'h260}, '{10'd420, 12'h000}  // grass below the castle, then black
    };
endpackage

`default_nettype wire

// File: hw/draw_ifs.sv
`default_nettype none
`timescale 1ns/1ps
// ##########################################################
// shape hand-off between sequencer and rasterizer, and the
// Wishbone classic write bus into the framebuffer
// ##########################################################

interface shape_if import gfx_pkg::*; ();
    logic   start;  // one-cycle pulse while rasterizer idle
    coord_t x0;
    coord_t y0;
    coord_t x1;
    coord_t y1;
    cidx_t  cidx;
    logic   done;   // one cycle after last pixel ack

    modport seq  (output start, x0, y0, x1, y1, cidx, input done);
    modport rast (input start, x0, y0, x1, y1, cidx, output done);
endinterface

interface wb_if import gfx_pkg::*; #(
    parameter int ADRW = 16
) ();
    logic            cyc;
    logic            stb;
    logic            we;
    logic [ADRW-1:0] adr;    // framebuffer word address
    cidx_t           dat_w;
    logic            ack;

    modport master (output cyc, stb, we, adr, dat_w, input ack);
    modport slave  (input cyc, stb, we, adr, dat_w, output ack);
endinterface

`default_nettype wire

// File: hw/display_timings.sv
`default_nettype none
`timescale 1ns/1ps
// ##########################################################
// 640x480 position counters with sync, data enable and the
// frame and line start pulses
// ##########################################################

module display_timings import gfx_pkg::*, video_pkg::*; (
    input  wire logic clk_pix,
    input  wire logic reset,
    output coord_t    sx,
    output coord_t    sy,
    output logic      hsync,
    output logic      vsync,
    output logic      de,
    output logic      frame,
    output logic      line
);
    localparam coord_t HS_STA = H_ACTIVE + H_FRONT;
    localparam coord_t HS_END = HS_STA + H_SYNC;
    localparam coord_t VS_STA = V_ACTIVE + V_FRONT;
    localparam coord_t VS_END = VS_STA + V_SYNC;
    localparam coord_t H_LAST = H_TOTAL - 1'b1;
    localparam coord_t V_LAST = V_TOTAL - 1'b1;

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sx <= H_LAST;  // park in blanking, frame start follows release
            sy <= V_LAST;
        end else if (sx == H_LAST) begin
            sx <= '0;
            sy <= (sy == V_LAST) ? '0 : sy + 1'b1;
        end else begin
            sx <= sx + 1'b1;
        end
    end

    always_comb begin
        hsync = ~(sx >= HS_STA && sx < HS_END);  // active low
        vsync = ~(sy >= VS_STA && sy < VS_END);
        de    = (sx < H_ACTIVE) && (sy < V_ACTIVE);
        frame = (sx == '0) && (sy == '0);
        line  = (sx == '0);  // row start for the background bands
    end
endmodule

`default_nettype wire

// File: hw/shape_sequencer.sv
`default_nettype none
`timescale 1ns/1ps
// ##########################################################
// clears the framebuffer, then hands every castle shape to
// the rasterizer in table order and flags completion
// ##########################################################

module shape_sequencer import gfx_pkg::*; #(
    parameter int FB_WIDTH  = 320,
    parameter int FB_HEIGHT = 180
) (
    input  wire logic clk_pix,
    input  wire logic reset,
    input  wire logic frame,
    shape_if.seq      shp,
    output logic      draw_done
);
    localparam int IDW = $clog2(SHAPE_CNT);

    enum logic [2:0] {IDLE, CLEAR, LOAD, WAIT, DONE} state;
    logic [IDW-1:0] shape_id;
    logic           clearing;  // clear rectangle in flight
    logic           start_q;
    shape_t         shape_q;   // geometry held until done

    always_ff @(posedge clk_pix) begin
        start_q <= 1'b0;
        case (state)
            IDLE: begin
                if (frame) state <= CLEAR;
            end
            CLEAR: begin
                shape_q <= '{x0: '0, y0: '0, x1: coord_t'(FB_WIDTH - 1),
                             y1: coord_t'(FB_HEIGHT - 1), cidx: '0};
                start_q  <= 1'b1;
                clearing <= 1'b1;
                state    <= WAIT;
            end
            LOAD: begin
                shape_q <= SHAPES[shape_id];
                start_q <= 1'b1;
                state   <= WAIT;
            end
            WAIT: begin
                if (shp.done) begin
                    if (clearing) begin
                        clearing <= 1'b0;
                        shape_id <= '0;
                        state    <= LOAD;
                    end else if (shape_id == IDW'(SHAPE_CNT - 1)) begin
                        state <= DONE;
                    end else begin
                        shape_id <= shape_id + 1'b1;
                        state    <= LOAD;
                    end
                end
            end
            DONE:    state <= DONE;  // hold until reset
            default: state <= IDLE;
        endcase
        if (reset) begin
            state    <= IDLE;
            start_q  <= 1'b0;
            clearing <= 1'b0;
            shape_id <= '0;
        end
    end

    assign shp.start = start_q;
    assign {shp.x0, shp.y0, shp.x1, shp.y1, shp.cidx} = shape_q;
    assign draw_done = (state == DONE);
endmodule

`default_nettype wire

// File: hw/draw_rect_fill.sv
`default_nettype none
`timescale 1ns/1ps
// ##########################################################
// filled rectangle rasterizer, walks the box row by row and
// writes each pixel to the framebuffer as a Wishbone master
// ##########################################################

module draw_rect_fill import gfx_pkg::*; #(
    parameter int FB_WIDTH = 320
) (
    input  wire logic clk_pix,
    input  wire logic reset,
    shape_if.rast     shp,
    wb_if.master      wb
);
    localparam int ADRW = wb.ADRW;

    coord_t          x;         // current pixel
    coord_t          y;
    coord_t          x0_q;
    coord_t          x1_q;
    coord_t          y1_q;
    cidx_t           cidx_q;
    logic [ADRW-1:0] row_base;  // y * FB_WIDTH
    logic            busy;
    logic            done_q;

    always_ff @(posedge clk_pix) begin
        done_q <= 1'b0;
        if (!busy) begin
            if (shp.start) begin
                x0_q     <= shp.x0;
                x1_q     <= shp.x1;
                y1_q     <= shp.y1;
                cidx_q   <= shp.cidx;
                x        <= shp.x0;
                y        <= shp.y0;
                row_base <= ADRW'(shp.y0 * FB_WIDTH);
                busy     <= 1'b1;
            end
        end else if (wb.ack) begin  // step only once the write landed
            if (x != x1_q) begin
                x <= x + 1'b1;
            end else if (y != y1_q) begin
                x        <= x0_q;
                y        <= y + 1'b1;
                row_base <= row_base + ADRW'(FB_WIDTH);
            end else begin
                busy   <= 1'b0;
                done_q <= 1'b1;
            end
        end
        if (reset) begin
            busy   <= 1'b0;
            done_q <= 1'b0;
        end
    end

    assign shp.done = done_q;

    // one write request per pixel, held across the ack cycle
    assign wb.cyc   = busy;
    assign wb.stb   = busy;
    assign wb.we    = busy;
    assign wb.adr   = row_base + ADRW'(x);
    assign wb.dat_w = cidx_q;
endmodule

`default_nettype wire

// File: hw/framebuffer.sv
`default_nettype none
`timescale 1ns/1ps
// ##########################################################
// indexed-colour pixel memory, Wishbone write port and a
// scaled letterbox read port following the display position
// ##########################################################

module framebuffer import gfx_pkg::*, video_pkg::*; #(
    parameter int FB_WIDTH  = 320,
    parameter int FB_HEIGHT = 180,
    parameter int FB_SCALE  = 2
) (
    input  wire logic   clk_pix,
    input  wire logic   reset,
    wb_if.slave         wb,
    input  wire coord_t sx,
    input  wire coord_t sy,
    input  wire logic   de,
    output cidx_t       pix_cidx
);
    localparam int DEPTH = FB_WIDTH * FB_HEIGHT;
    localparam int ADRW  = $clog2(DEPTH);

    cidx_t           mem [DEPTH];
    logic            ack_q;
    logic            in_box;    // display position inside the letterbox
    logic            in_box_q;
    coord_t          fb_x;
    coord_t          fb_y;
    logic [ADRW-1:0] rd_adr;
    cidx_t           rd_cidx;

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= wb.cyc && wb.stb && !ack_q;  // one ack per request
        end
    end

    always_ff @(posedge clk_pix) begin
        if (wb.cyc && wb.stb && wb.we && !ack_q) mem[wb.adr] <= wb.dat_w;
    end

    assign wb.ack = ack_q;

    always_comb begin
        in_box = de && (sy >= LBOX_TOP) && (sy < LBOX_BOTTOM);
        fb_x   = coord_t'(sx / FB_SCALE);
        fb_y   = coord_t'((sy - LBOX_TOP) / FB_SCALE);
        rd_adr = in_box ? ADRW'(fb_y * FB_WIDTH + fb_x) : '0;
    end

    always_ff @(posedge clk_pix) begin
        rd_cidx <= mem[rd_adr];
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            in_box_q <= 1'b0;
        end else begin
            in_box_q <= in_box;  // aligned with the memory read
        end
    end

    assign pix_cidx = in_box_q ? rd_cidx : '0;
endmodule

`default_nettype wire

// File: hw/pixel_compose.sv
`default_nettype none
`timescale 1ns/1ps
// ##########################################################
// palette lookup with background bands behind index 0, and
// the registered video outputs
// ##########################################################

module pixel_compose import gfx_pkg::*, video_pkg::*; (
    input  wire logic   clk_pix,
    input  wire logic   reset,
    input  wire logic   line,
    input  wire coord_t sy,
    input  wire logic   hsync,
    input  wire logic   vsync,
    input  wire logic   de,
    input  wire cidx_t  pix_cidx,
    output logic        vga_hsync,
    output logic        vga_vsync,
    output logic        vga_de,
    output logic [3:0]  vga_r,
    output logic [3:0]  vga_g,
    output logic [3:0]  vga_b
);
    rgb_t bg_colr;   // background of the current row
    rgb_t bg_next;
    rgb_t pix_colr;
    logic hsync_d;   // matches the framebuffer read
    logic vsync_d;
    logic de_d;

    always_comb begin
        bg_next = BG_BANDS[0].colr;
        for (int i = 1; i < BG_CNT; i++) begin
            if (sy >= BG_BANDS[i].row) bg_next = BG_BANDS[i].colr;  // bands are ascending
        end
    end

    always_comb begin
        if (!de_d) begin
            pix_colr = '0;
        end else if (pix_cidx == '0) begin
            pix_colr = bg_colr;  // transparent index
        end else begin
            pix_colr = PALETTE[pix_cidx];
        end
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            bg_colr   <= '0;
            hsync_d   <= 1'b1;
            vsync_d   <= 1'b1;
            de_d      <= 1'b0;
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            vga_de    <= 1'b0;
            {vga_r, vga_g, vga_b} <= '0;
        end else begin
            if (line) bg_colr <= bg_next;
            hsync_d   <= hsync;
            vsync_d   <= vsync;
            de_d      <= de;
            vga_hsync <= hsync_d;
            vga_vsync <= vsync_d;
            vga_de    <= de_d;
            {vga_r, vga_g, vga_b} <= pix_colr;
        end
    end
endmodule

`default_nettype wire

// File: hw/castle_top.sv
`default_nettype none
`timescale 1ns/1ps
// ##########################################################
// castle renderer top, timing, draw pipeline, framebuffer
// and output stage, sets the framebuffer geometry
// ##########################################################

module castle_top import gfx_pkg::*; #(
    parameter int FB_WIDTH  = 320,
    parameter int FB_HEIGHT = 180,
    parameter int FB_SCALE  = 2
) (
    input  wire logic  clk_pix,
    input  wire logic  reset,
    output logic       vga_hsync,
    output logic       vga_vsync,
    output logic       vga_de,
    output logic [3:0] vga_r,
    output logic [3:0] vga_g,
    output logic [3:0] vga_b,
    output logic       draw_done
);
    localparam int FB_ADRW = $clog2(FB_WIDTH * FB_HEIGHT);

    coord_t sx;
    coord_t sy;
    logic   hsync;
    logic   vsync;
    logic   de;
    logic   frame;
    logic   line;
    cidx_t  pix_cidx;  // framebuffer index, one cycle behind sx/sy

    shape_if shp ();
    wb_if #(.ADRW(FB_ADRW)) wb ();

    display_timings display_timings_inst (
        .clk_pix, .reset, .sx, .sy, .hsync, .vsync, .de, .frame, .line
    );

    shape_sequencer #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) shape_sequencer_inst (
        .clk_pix, .reset, .frame, .shp, .draw_done
    );

    draw_rect_fill #(.FB_WIDTH(FB_WIDTH)) draw_rect_fill_inst (
        .clk_pix, .reset, .shp, .wb
    );

    framebuffer #(
        .FB_WIDTH(FB_WIDTH),
        .FB_HEIGHT(FB_HEIGHT),
        .FB_SCALE(FB_SCALE)
    ) framebuffer_inst (
        .clk_pix, .reset, .wb, .sx, .sy, .de, .pix_cidx
    );

    pixel_compose pixel_compose_inst (
        .clk_pix, .reset, .line, .sy, .hsync, .vsync, .de, .pix_cidx,
        .vga_hsync, .vga_vsync, .vga_de, .vga_r, .vga_g, .vga_b
    );
endmodule

`default_nettype wire

// File: tb/tb_clock.sv
`default_nettype none
`timescale 1ns/1ps
// ##########################################################
// 10 ns pixel clock and power-on reset for the testbench
// ##########################################################

module tb_clock #(
    parameter int RESET_CYCLES = 10
) (
    output logic clk_pix,
    output logic por
);
    initial begin
        clk_pix = 1'b0;
        forever #5 clk_pix = ~clk_pix;
    end

    initial begin
        por = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_pix);
        #1 por = 1'b0;  // released just after the edge
    end
endmodule

`default_nettype wire

// File: tb/castle_properties.sv
`default_nettype none
`timescale 1ns/1ps
// ##########################################################
// Wishbone handshake checks bound to the rasterizer and the
// framebuffer plus an address range check where DEPTH is set
// ##########################################################

module wb_write_checks #(
    parameter int ADRW  = 16,
    parameter int DEPTH = 0
) (
    input wire logic            clk_pix,
    input wire logic            reset,
    input wire logic            cyc,
    input wire logic            stb,
    input wire logic [ADRW-1:0] adr,
    input wire logic            ack
);
    stb_needs_cyc: assert property (@(posedge clk_pix) disable iff (reset) stb |-> cyc)
        else $error("stb high without cyc");

    if (DEPTH > 0) begin : range_check
        adr_in_range: assert property (@(posedge clk_pix) disable iff (reset)
            stb |-> (adr < DEPTH))
            else $error("write address %0d outside the framebuffer", adr);
    end

    held_until_ack: assert property (@(posedge clk_pix) disable iff (reset)
        (stb && !ack) |=> (stb && $stable(adr)))
        else $error("request dropped or address moved before ack");

    single_ack: assert property (@(posedge clk_pix) disable iff (reset) ack |=> !ack)
        else $error("ack high for two cycles in a row");
endmodule

bind draw_rect_fill wb_write_checks #(.ADRW(ADRW)) master_checks (
    .clk_pix, .reset, .cyc(wb.cyc), .stb(wb.stb), .adr(wb.adr), .ack(wb.ack)
);

bind framebuffer wb_write_checks #(.ADRW(ADRW), .DEPTH(DEPTH)) slave_checks (
    .clk_pix, .reset, .cyc(wb.cyc), .stb(wb.stb), .adr(wb.adr), .ack(wb.ack)
);

`default_nettype wire

// File: tb/castle_tb.sv
`default_nettype none
`timescale 1ns/1ps
// ##########################################################
// directed tests of the castle renderer for reset, video
// timing, drawing and scene content, built from src.f
// ##########################################################

module castle_tb import gfx_pkg::*, video_pkg::*; ();
    localparam int FB_PIXELS    = 320 * 180;  // clear rectangle
    localparam int FRAME_CYCLES = int'(H_TOTAL) * int'(V_TOTAL);
    localparam int MAX_PTS      = 16;

    logic       clk_pix;
    logic       por;
    logic       reset_req = 1'b0;
    logic       reset;
    logic       vga_hsync;
    logic       vga_vsync;
    logic       vga_de;
    logic [3:0] vga_r;
    logic [3:0] vga_g;
    logic [3:0] vga_b;
    logic       draw_done;

    int   errors = 0;
    int   tests_failed = 0;
    int   test_no = 0;     // watchdog restarts on change
    int   pt_x [MAX_PTS];  // display points of the current capture
    int   pt_y [MAX_PTS];
    rgb_t pt_colr [MAX_PTS];
    bit   pt_seen [MAX_PTS];
    int   pt_cnt = 0;
    bit   cap_req = 1'b0;
    bit   cap_done = 1'b0;
    bit   armed = 1'b0;
    int   row = -1;        // rebuilt display position
    int   col = 0;
    logic vsync_prev = 1'b1;
    logic de_prev = 1'b0;

    tb_clock clock_inst (.clk_pix, .por);

    assign reset = por || reset_req;

    castle_top castle_top_inst (
        .clk_pix, .reset, .vga_hsync, .vga_vsync, .vga_de,
        .vga_r, .vga_g, .vga_b, .draw_done
    );

    function automatic longint shape_area_sum();
        longint sum;
        int     w;
        int     h;
        sum = 0;
        foreach (SHAPES[i]) begin
            w = int'(SHAPES[i].x1) - int'(SHAPES[i].x0) + 1;
            h = int'(SHAPES[i].y1) - int'(SHAPES[i].y0) + 1;
            sum += longint'(w * h);
        end
        return sum;
    endfunction

    function automatic rgb_t band_colour(int dy);
        rgb_t c;
        c = 12'h000;
        foreach (BG_BANDS[i]) begin
            if (dy >= int'(BG_BANDS[i].row)) c = BG_BANDS[i].colr;  // last band started
        end
        return c;
    endfunction

    // display point to framebuffer pixel, scaled by 2 below the top bar
    function automatic rgb_t expected_colour(int dx, int dy);
        int    fx;
        int    fy;
        cidx_t c;
        if (dy < int'(LBOX_TOP) || dy >= int'(LBOX_BOTTOM)) return 12'h000;
        fx = dx / 2;
        fy = (dy - int'(LBOX_TOP)) / 2;
        c  = 4'h0;
        foreach (SHAPES[i]) begin
            if (fx >= int'(SHAPES[i].x0) && fx <= int'(SHAPES[i].x1) &&
                fy >= int'(SHAPES[i].y0) && fy <= int'(SHAPES[i].y1)) c = SHAPES[i].cidx;
        end
        return (c == 4'h0) ? band_colour(dy) : PALETTE[c];
    endfunction

    always @(negedge clk_pix) begin
        if (vsync_prev && !vga_vsync) begin
            row = -1;
            if (cap_req && armed) begin
                cap_done = 1'b1;  // one whole frame seen
                armed    = 1'b0;
            end else if (cap_req && !cap_done) begin
                armed = 1'b1;
                for (int i = 0; i < MAX_PTS; i++)
                    pt_seen[i] = 1'b0;
            end
        end
        if (vga_de && !de_prev) begin
            row++;
            col = 0;
        end
        if (vga_de && armed) begin
            for (int i = 0; i < pt_cnt; i++) begin
                if (pt_x[i] == col && pt_y[i] == row) begin
                    pt_colr[i] = {vga_r, vga_g, vga_b};
                    pt_seen[i] = 1'b1;
                end
            end
        end
        if (vga_de) col++;
        if (!cap_req) begin
            cap_done = 1'b0;
            armed    = 1'b0;
        end
        vsync_prev = vga_vsync;
        de_prev    = vga_de;
    end

    initial begin : watchdog
        longint limit;
        longint count;
        int     seen_test;
        limit     = 2 * (longint'(FB_PIXELS) * 2 + shape_area_sum() * 2 +
                         3 * longint'(FRAME_CYCLES));
        count     = 0;
        seen_test = 0;
        while (count < limit) begin
            @(posedge clk_pix);
            if (test_no != seen_test) begin
                seen_test = test_no;
                count     = 0;
            end else begin
                count++;
            end
        end
        $display("watchdog: test %0d ran longer than %0d cycles", test_no, limit);
        $display("Simulation FAILED");
        $finish;
    end

    task automatic report_test(string name, int errs_before);
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic pulse_reset();
        @(posedge clk_pix);
        #1 reset_req = 1'b1;
        repeat (10) @(posedge clk_pix);
        #1 reset_req = 1'b0;
    endtask

    task automatic add_point(int x, int y);
        pt_x[pt_cnt] = x;
        pt_y[pt_cnt] = y;
        pt_cnt++;
    endtask

    task automatic load_scene_points();
        pt_cnt = 0;
        add_point(160, 260);  // main building
        add_point(250, 170);  // middle window
        add_point(100, 136);  // left roof
        add_point(230, 120);  // middle roof
        add_point(400, 260);  // right tower
        add_point(170, 192);  // battlement
        add_point(320, 30);   // top bar
        add_point(320, 420);  // first row of the bottom bar
        add_point(100, 470);
    endtask

    task automatic capture_and_check(string name);
        rgb_t exp;
        cap_req = 1'b1;
        wait (cap_done);
        for (int i = 0; i < pt_cnt; i++) begin
            exp = expected_colour(pt_x[i], pt_y[i]);
            assert (pt_seen[i]) else begin
                $display("%s: display point (%0d,%0d) never appeared in the frame",
                         name, pt_x[i], pt_y[i]);
                errors++;
            end
            assert (!pt_seen[i] || pt_colr[i] == exp) else begin
                $display("MISMATCH %s at (%0d,%0d): expected %h actual %h",
                         name, pt_x[i], pt_y[i], exp, pt_colr[i]);
                errors++;
            end
        end
        cap_req = 1'b0;
        wait (!cap_done);
    endtask

    task automatic check_idle_outputs();
        logic [13:0] got;
        got = {draw_done, vga_de, vga_r, vga_g, vga_b};
        assert (got == '0) else begin
            $display("MISMATCH reset_state: {draw_done,de,rgb} expected %h actual %h",
                     14'h0, got);
            errors++;
        end
    endtask

    task automatic test_reset_state();
        int errs;
        errs    = errors;
        test_no = 1;
        @(negedge clk_pix);
        check_idle_outputs();
        while (por) begin
            @(negedge clk_pix);
            check_idle_outputs();
        end
        @(negedge clk_pix);  // first cycle out of reset
        check_idle_outputs();
        report_test("reset_state", errs);
    endtask

    task automatic test_video_timing();
        int   errs;
        int   de_cnt;
        int   lines;
        int   gap;
        logic vs_p;
        logic hs_p;
        logic de_p;
        bit   falling;
        errs    = errors;
        test_no = 2;
        vs_p    = vga_vsync;
        falling = 1'b0;
        while (!falling) begin  // find a frame start
            @(negedge clk_pix);
            falling = vs_p && !vga_vsync;
            vs_p    = vga_vsync;
        end
        hs_p    = vga_hsync;
        de_p    = vga_de;
        de_cnt  = 0;
        lines   = 0;
        gap     = -1;
        falling = 1'b0;
        while (!falling) begin
            @(negedge clk_pix);
            if (vga_de) de_cnt++;
            if (de_p && !vga_de) begin
                lines++;
                assert (de_cnt == int'(H_ACTIVE)) else begin
                    $display(
                        "MISMATCH video_timing: de cycles in line %0d expected %0d actual %0d",
                        lines, H_ACTIVE, de_cnt);
                    errors++;
                end
                de_cnt = 0;
            end
            if (gap >= 0) gap++;
            if (hs_p && !vga_hsync) begin
                assert (gap < 0 || gap == int'(H_TOTAL)) else begin
                    $display("MISMATCH video_timing: hsync spacing expected %0d actual %0d",
                             H_TOTAL, gap);
                    errors++;
                end
                gap = 0;
            end
            falling = vs_p && !vga_vsync;
            vs_p    = vga_vsync;
            hs_p    = vga_hsync;
            de_p    = vga_de;
        end
        assert (lines == int'(V_ACTIVE)) else begin
            $display("MISMATCH video_timing: de lines per frame expected %0d actual %0d",
                     V_ACTIVE, lines);
            errors++;
        end
        report_test("video_timing", errs);
    endtask

    task automatic test_draw_done();
        int   errs;
        int   frames;
        bit   dropped;
        logic vs_p;
        errs    = errors;
        test_no = 3;
        while (!draw_done) @(negedge clk_pix);
        frames  = 0;
        dropped = 1'b0;
        vs_p    = vga_vsync;
        while (frames < 2) begin
            @(negedge clk_pix);
            if (vs_p && !vga_vsync) frames++;
            if (!draw_done) dropped = 1'b1;
            vs_p = vga_vsync;
        end
        assert (!dropped) else begin
            $display("draw_done: flag fell again within two frames of completion");
            errors++;
        end
        report_test("draw_done", errs);
    endtask

    task automatic test_scene();
        int errs;
        errs    = errors;
        test_no = 4;
        load_scene_points();
        capture_and_check("scene");
        report_test("scene", errs);
    endtask

    task automatic test_background();
        int errs;
        errs    = errors;
        test_no = 5;
        pt_cnt  = 0;
        add_point(0, 60);     // first letterbox row
        add_point(20, 80);
        add_point(500, 260);
        add_point(600, 360);  // grass band
        add_point(10, 400);
        add_point(639, 419);
        add_point(250, 280);  // drawbridge over main building
        add_point(224, 244);  // arch over drawbridge
        capture_and_check("background");
        report_test("background", errs);
    endtask

    task automatic test_reset_redraw();
        int     errs;
        int     cycles;
        longint min_cycles;
        errs       = errors;
        test_no    = 6;
        min_cycles = longint'(FB_PIXELS) * 2 + shape_area_sum() * 2;
        pulse_reset();  // fresh drawing pass
        repeat (20000) @(negedge clk_pix);
        assert (!draw_done) else begin
            $display("reset_redraw: draw_done already high before the second reset");
            errors++;
        end
        pulse_reset();  // lands inside the clear
        cycles = 0;
        while (!draw_done) begin
            @(negedge clk_pix);
            cycles++;
        end
        assert (cycles >= min_cycles) else begin
            $display("MISMATCH reset_redraw: cycles to draw_done expected >= %0d actual %0d",
                     min_cycles, cycles);
            errors++;
        end
        load_scene_points();
        capture_and_check("reset_redraw");
        report_test("reset_redraw", errs);
    endtask

    initial begin
        test_reset_state();
        test_video_timing();
        test_draw_done();
        test_scene();
        test_background();
        test_reset_redraw();
        $display("tests run 6, tests with errors %0d, errors %0d", tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end
endmodule

`default_nettype wire

// File: src.f
hw/gfx_pkg.sv
hw/video_pkg.sv
hw/draw_ifs.sv
hw/display_timings.sv
hw/shape_sequencer.sv
hw/draw_rect_fill.sv
hw/framebuffer.sv
hw/pixel_compose.sv
hw/castle_top.sv
tb/tb_clock.sv
tb/castle_properties.sv
tb/castle_tb.sv

// File: Makefile
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -j 0
TOP        ?= castle_tb
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   := Simulation FAILED
PASS_MSG   := Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "failure reported, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "run ended without a result, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
